// File: list.f
logic/udp_app_pkg.sv
logic/key_debounce.sv
logic/led_cmd_tx.sv
logic/mode_cmd_tx.sv
logic/img_packet_tx.sv
logic/tx_arbiter.sv
logic/udp_app_top.sv
testbench/udp_app_checker.sv
testbench/tb_udp_app.sv

// File: logic/img_packet_tx.sv
`timescale 1ns/1ps

module img_packet_tx (
    input  logic                   clk_25_out,
    input  logic                   key1,
    input  logic                   press,
    input  udp_app_pkg::pixel_t    word,
    input  logic                   word_valid,
    output logic                   word_ready,
    output udp_app_pkg::app_beat_t beat,
    output logic                   valid,
    input  logic                   ready,
    output logic                   img_mode
);
    import udp_app_pkg::*;

    pixel_t               fifo_mem [IMG_FIFO_DEPTH];
    logic [IMG_PTR_W-1:0] wr_ptr;
    logic [IMG_PTR_W-1:0] rd_ptr;
    logic [IMG_CNT_W-1:0] fifo_cnt;
    logic                 push;
    logic                 pop;
    logic                 toggle;
    tx_state_t            state;
    pkt_len_t             byte_cnt;
    pkt_len_t             word_off;   // byte offset past the seq field
    seq_t                 seq;
    pixel_t               head;

    assign toggle     = press && (state == IDLE);
    assign word_ready = (fifo_cnt != IMG_CNT_W'(IMG_FIFO_DEPTH));
    assign push       = word_valid && word_ready && img_mode;  // dropped when mode is off
    assign word_off   = byte_cnt - 16'd2;
    assign pop        = valid && ready && (byte_cnt >= 16'd2) && (word_off[1:0] == 2'b11);
    assign head       = fifo_mem[rd_ptr];
    assign valid      = (state == SEND);

    // ------------------------------------------------------------------------
    // pixel word fifo
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_25_out)
    begin
        if (push)
            fifo_mem[wr_ptr] <= word;
    end

    always_ff @(posedge clk_25_out or negedge key1)
    begin
        if (!key1)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end
        else if (toggle)
        begin
            // mode change flushes whatever is buffered
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)
                fifo_cnt <= fifo_cnt + 1'b1;
            else if (pop && !push)
                fifo_cnt <= fifo_cnt - 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // packet serializer: seq hi, seq lo, then words msb first
    // ------------------------------------------------------------------------
    always_comb
    begin
        beat.len  = IMG_PKT_LEN;
        beat.last = (byte_cnt == IMG_PKT_LEN - 16'd1);
        if (byte_cnt == 16'd0)
            beat.data = seq[15:8];
        else if (byte_cnt == 16'd1)
            beat.data = seq[7:0];
        else
            case (word_off[1:0])
                2'd0:    beat.data = head[31:24];
                2'd1:    beat.data = head[23:16];
                2'd2:    beat.data = head[15:8];
                default: beat.data = head[7:0];
            endcase
    end

    always_ff @(posedge clk_25_out or negedge key1)
    begin
        if (!key1)
        begin
            state    <= IDLE;
            byte_cnt <= '0;
            seq      <= '0;
            img_mode <= 1'b0;
        end
        else if (state == IDLE)
        begin
            if (toggle)
            begin
                img_mode <= !img_mode;
                if (!img_mode)
                    seq <= '0;                  // entering image mode
            end
            else if (img_mode && fifo_cnt >= IMG_CNT_W'(IMG_WORDS_PER_PKT))
            begin
                byte_cnt <= '0;
                state    <= SEND;
            end
        end
        else if (valid && ready)
        begin
            if (beat.last)
            begin
                seq   <= seq + 16'd1;
                state <= IDLE;
            end
            else
                byte_cnt <= byte_cnt + 16'd1;
        end
    end

endmodule

// File: logic/key_debounce.sv
`timescale 1ns/1ps

module key_debounce (
    input  logic clk_25_out,
    input  logic key1,
    input  logic key,    // active low button
    output logic press   // one cycle per press
);
    import udp_app_pkg::*;

    logic                      key_meta;
    logic                      key_sync;
    logic [DEBOUNCE_CNT_W-1:0] low_cnt;

    // two flop synchronizer, idles high like a released button
    always_ff @(posedge clk_25_out or negedge key1)
    begin
        if (!key1)
        begin
            key_meta <= 1'b1;
            key_sync <= 1'b1;
        end
        else
        begin
            key_meta <= key;
            key_sync <= key_meta;
        end
    end

    // count low samples, park one above the threshold until release
    always_ff @(posedge clk_25_out or negedge key1)
    begin
        if (!key1)
        begin
            low_cnt <= '0;
            press   <= 1'b0;
        end
        else
        begin
            press <= !key_sync && (low_cnt == DEBOUNCE_CNT_W'(DEBOUNCE_CYCLES));
            if (key_sync)
                low_cnt <= '0;                                // released, rearm
            else if (low_cnt != DEBOUNCE_CNT_W'(DEBOUNCE_CYCLES + 1))
                low_cnt <= low_cnt + 1'b1;
        end
    end

endmodule

// File: logic/led_cmd_tx.sv
`timescale 1ns/1ps

module led_cmd_tx (
    input  logic                   clk_25_out,
    input  logic                   key1,
    input  logic                   press,
    output udp_app_pkg::app_beat_t beat,
    output logic                   valid,
    input  logic                   ready
);
    import udp_app_pkg::*;

    tx_state_t            state;
    pkt_len_t             byte_cnt;
    logic [LED_IDX_W-1:0] led_idx;     // current led / segment pattern
    byte_t                idx_byte;

    assign idx_byte = {{(8 - LED_IDX_W){1'b0}}, led_idx};
    assign valid    = (state == SEND);

    // packet is tag, 01, index, ~index
    always_comb
    begin
        beat.len  = LED_CMD_LEN;
        beat.last = (byte_cnt == LED_CMD_LEN - 16'd1);
        case (byte_cnt[1:0])
            2'd0:    beat.data = LED_CMD_TAG;
            2'd1:    beat.data = 8'h01;
            2'd2:    beat.data = idx_byte;
            default: beat.data = ~idx_byte;
        endcase
    end

    always_ff @(posedge clk_25_out or negedge key1)
    begin
        if (!key1)
        begin
            state    <= IDLE;
            byte_cnt <= '0;
            led_idx  <= '0;
        end
        else if (state == IDLE)
        begin
            if (press)
            begin
                led_idx  <= (led_idx == LED_IDX_W'(LED_PATTERNS - 1)) ? '0 : led_idx + 1'b1;
                byte_cnt <= '0;
                state    <= SEND;
            end
        end
        else if (valid && ready)
        begin
            if (beat.last)
                state <= IDLE;
            else
                byte_cnt <= byte_cnt + 16'd1;
        end
    end

endmodule

// File: logic/mode_cmd_tx.sv
`timescale 1ns/1ps

module mode_cmd_tx (
    input  logic                   clk_25_out,
    input  logic                   key1,
    input  logic                   press,
    output udp_app_pkg::app_beat_t beat,
    output logic                   valid,
    input  logic                   ready
);
    import udp_app_pkg::*;

    tx_state_t   state;
    pkt_len_t    byte_cnt;
    logic        use_b;      // next command is MODE_CMD_B
    logic [15:0] cmd;

    assign cmd   = use_b ? MODE_CMD_B : MODE_CMD_A;
    assign valid = (state == SEND);

    // big endian command word
    always_comb
    begin
        beat.len  = MODE_CMD_LEN;
        beat.last = (byte_cnt == MODE_CMD_LEN - 16'd1);
        beat.data = (byte_cnt == 16'd0) ? cmd[15:8] : cmd[7:0];
    end

    always_ff @(posedge clk_25_out or negedge key1)
    begin
        if (!key1)
        begin
            state    <= IDLE;
            byte_cnt <= '0;
            use_b    <= 1'b0;
        end
        else if (state == IDLE)
        begin
            if (press)
            begin
                byte_cnt <= '0;
                state    <= SEND;
            end
        end
        else if (valid && ready)
        begin
            if (beat.last)
            begin
                use_b <= !use_b;                // flip once the command is out
                state <= IDLE;
            end
            else
                byte_cnt <= byte_cnt + 16'd1;
        end
    end

endmodule

// File: logic/tx_arbiter.sv
`timescale 1ns/1ps

module tx_arbiter (
    input  logic                   clk_25_out,
    input  logic                   key1,
    input  udp_app_pkg::app_beat_t mode_beat,
    input  udp_app_pkg::app_beat_t img_beat,
    input  udp_app_pkg::app_beat_t led_beat,
    input  logic                   mode_valid,
    input  logic                   img_valid,
    input  logic                   led_valid,
    output logic                   mode_ready,
    output logic                   img_ready,
    output logic                   led_ready,
    input  logic                   img_mode,
    output udp_app_pkg::app_beat_t out_beat,
    output logic                   out_valid,
    input  logic                   out_ready
);
    import udp_app_pkg::*;

    arb_state_t state;
    arb_state_t grant;   // FREE here means nobody

    // priority: mode, then img in image mode, else led
    always_comb
    begin
        grant = state;
        if (state == FREE)
        begin
            if (mode_valid)
                grant = LOCK_MODE;
            else if (img_mode)
                grant = img_valid ? LOCK_IMG : FREE;
            else if (led_valid)
                grant = LOCK_LED;
        end
    end

    always_comb
    begin
        out_beat   = '0;
        out_valid  = 1'b0;
        mode_ready = 1'b0;
        img_ready  = 1'b0;
        led_ready  = 1'b0;
        case (grant)
            LOCK_MODE:
            begin
                out_beat   = mode_beat;
                out_valid  = mode_valid;
                mode_ready = out_ready;
            end
            LOCK_IMG:
            begin
                out_beat  = img_beat;
                out_valid = img_valid;
                img_ready = out_ready;
            end
            LOCK_LED:
            begin
                out_beat  = led_beat;
                out_valid = led_valid;
                led_ready = out_ready;
            end
            default:
            begin
                out_valid = 1'b0;
            end
        endcase
    end

    // lock as soon as a beat is shown, so a stalled beat never changes
    always_ff @(posedge clk_25_out or negedge key1)
    begin
        if (!key1)
            state <= FREE;
        else if (out_valid && out_ready && out_beat.last)
            state <= FREE;
        else if (out_valid)
            state <= grant;
    end

endmodule

// File: logic/udp_app_pkg.sv
package udp_app_pkg;

    // ------------------------------------------------------------------------
    // widths with a meaning
    // ------------------------------------------------------------------------
    typedef logic [7:0]  byte_t;     // one payload byte
    typedef logic [15:0] pkt_len_t;  // udp payload length
    typedef logic [31:0] pixel_t;    // {r, g, b, pad}
    typedef logic [15:0] seq_t;      // image packet number

    typedef struct packed {
        byte_t    data;
        logic     last;  // final byte of packet
        pkt_len_t len;   // whole packet length, same on every beat
    } app_beat_t;

    typedef enum logic {IDLE, SEND} tx_state_t;
    typedef enum logic [1:0] {FREE, LOCK_MODE, LOCK_IMG, LOCK_LED} arb_state_t;

    // ------------------------------------------------------------------------
    // protocol constants
    // ------------------------------------------------------------------------
    localparam int       DEBOUNCE_CYCLES   = 16;  // short, keeps simulation quick
    localparam int       DEBOUNCE_CNT_W    = $clog2(DEBOUNCE_CYCLES + 2);

    localparam byte_t    LED_CMD_TAG       = 8'hA5;
    localparam pkt_len_t LED_CMD_LEN       = 16'd4;
    localparam int       LED_PATTERNS      = 4;
    localparam int       LED_IDX_W         = $clog2(LED_PATTERNS);

    localparam pkt_len_t MODE_CMD_LEN      = 16'd2;
    localparam logic [15:0] MODE_CMD_A     = 16'h0001;
    localparam logic [15:0] MODE_CMD_B     = 16'h0003;

    localparam int       IMG_WORDS_PER_PKT = 4;
    localparam pkt_len_t IMG_PKT_LEN       = 16'd18;  // 2 seq bytes + 16 pixel bytes
    localparam int       IMG_FIFO_DEPTH    = 16;
    localparam int       IMG_PTR_W         = $clog2(IMG_FIFO_DEPTH);
    localparam int       IMG_CNT_W         = IMG_PTR_W + 1;

endpackage

// File: logic/udp_app_top.sv
`timescale 1ns/1ps

module udp_app_top (
    input  logic                   clk_25_out,
    input  logic                   key1,            // reset, active low
    input  logic                   key2,            // led command
    input  logic                   key3,            // image mode toggle
    input  logic                   key4,            // mode command
    input  udp_app_pkg::pixel_t    img_word,
    input  logic                   img_word_valid,
    output logic                   img_word_ready,
    output udp_app_pkg::app_beat_t udp_tx,
    output logic                   udp_tx_valid,
    input  logic                   udp_tx_ready,
    output logic                   img_mode
);
    import udp_app_pkg::*;

    logic      key2_press;
    logic      key3_press;
    logic      key4_press;
    app_beat_t led_beat;
    app_beat_t mode_beat;
    app_beat_t img_beat;
    logic      led_valid;
    logic      mode_valid;
    logic      img_valid;
    logic      led_ready;
    logic      mode_ready;
    logic      img_ready;

    // ------------------------------------------------------------------------
    // buttons
    // ------------------------------------------------------------------------
    key_debounce u_key2_db (.clk_25_out(clk_25_out), .key1(key1), .key(key2), .press(key2_press));
    key_debounce u_key3_db (.clk_25_out(clk_25_out), .key1(key1), .key(key3), .press(key3_press));
    key_debounce u_key4_db (.clk_25_out(clk_25_out), .key1(key1), .key(key4), .press(key4_press));

    // ------------------------------------------------------------------------
    // packet senders
    // ------------------------------------------------------------------------
    led_cmd_tx u_led_tx (
        .clk_25_out (clk_25_out), .key1 (key1), .press (key2_press),
        .beat       (led_beat),   .valid(led_valid), .ready (led_ready)
    );

    mode_cmd_tx u_mode_tx (
        .clk_25_out (clk_25_out), .key1 (key1), .press (key4_press),
        .beat       (mode_beat),  .valid(mode_valid), .ready (mode_ready)
    );

    img_packet_tx u_img_tx (
        .clk_25_out (clk_25_out), .key1       (key1),           .press (key3_press),
        .word       (img_word),   .word_valid (img_word_valid), .word_ready (img_word_ready),
        .beat       (img_beat),   .valid      (img_valid),      .ready (img_ready),
        .img_mode   (img_mode)
    );

    // single payload stream toward the udp stack
    tx_arbiter u_arbiter (
        .clk_25_out (clk_25_out), .key1       (key1),
        .mode_beat  (mode_beat),  .img_beat   (img_beat),   .led_beat  (led_beat),
        .mode_valid (mode_valid), .img_valid  (img_valid),  .led_valid (led_valid),
        .mode_ready (mode_ready), .img_ready  (img_ready),  .led_ready (led_ready),
        .img_mode   (img_mode),
        .out_beat   (udp_tx),     .out_valid  (udp_tx_valid), .out_ready (udp_tx_ready)
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the udp application testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_udp_app -Mdir obj_dir
./obj_dir/Vtb_udp_app +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q ">>> FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// File: testbench/tb_udp_app.sv
`timescale 1ns/1ps

module tb_udp_app;
    import udp_app_pkg::*;

    localparam int TIMEOUT_CYCLES = 20000;  // whole run needs under 3000 cycles

    logic      clk_25_out = 1'b0;
    logic      key1;
    logic      key2;
    logic      key3;
    logic      key4;
    pixel_t    img_word;
    logic      img_word_valid;
    logic      img_word_ready;
    app_beat_t udp_tx;
    logic      udp_tx_valid;
    logic      udp_tx_ready;
    logic      img_mode;

    logic [15:0] lfsr         = 16'd56493;
    bit          random_ready = 1'b0;
    int          cycle_cnt    = 0;
    int          error_cnt    = 0;
    int          check_cnt    = 0;
    int          test_cnt     = 0;
    int          test_errors  = 0;
    string       test_name;

    byte_t    rx_data [$];      // accepted bytes, packets back to back
    pkt_len_t rx_len [$];       // len field of each packet's first beat
    int       rx_cnt [$];       // bytes up to and including last
    int       cur_cnt = 0;
    pkt_len_t cur_len;

    byte_t    exp_bytes [$];
    pixel_t   sent_words [$];   // words that entered the image fifo
    seq_t     exp_seq     = '0;
    int       exp_led_idx = 0;
    bit       exp_mode_b  = 1'b0;

    udp_app_top dut (
        .clk_25_out     (clk_25_out),
        .key1           (key1),
        .key2           (key2),
        .key3           (key3),
        .key4           (key4),
        .img_word       (img_word),
        .img_word_valid (img_word_valid),
        .img_word_ready (img_word_ready),
        .udp_tx         (udp_tx),
        .udp_tx_valid   (udp_tx_valid),
        .udp_tx_ready   (udp_tx_ready),
        .img_mode       (img_mode)
    );

    bind tx_arbiter udp_app_checker u_checker (
        .clk_25_out (clk_25_out),
        .key1       (key1),
        .out_beat   (out_beat),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

    always #20 clk_25_out = !clk_25_out;

    always @(posedge clk_25_out)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES)
        begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    // packet collector on the udp_tx stream
    always @(posedge clk_25_out)
    begin
        if (key1 && udp_tx_valid && udp_tx_ready)
        begin
            if (cur_cnt == 0)
                cur_len = udp_tx.len;
            rx_data.push_back(udp_tx.data);
            cur_cnt = cur_cnt + 1;
            if (udp_tx.last)
            begin
                rx_len.push_back(cur_len);
                rx_cnt.push_back(cur_cnt);
                cur_cnt = 0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    function automatic bit next_bit();
        bit fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];  // x^16+x^14+x^13+x^11
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic pixel_t random_word();
        pixel_t w;
        w = '0;
        for (int i = 0; i < 32; i++)
            w = {w[30:0], next_bit()};
        return w;
    endfunction

    task automatic tick();
        @(posedge clk_25_out);
        #2;
        if (random_ready)
            udp_tx_ready = next_bit() & next_bit();  // ready about one cycle in four
    endtask

    task automatic drive_key(input int which, input logic level);
        case (which)
            2:       key2 = level;
            3:       key3 = level;
            default: key4 = level;
        endcase
    endtask

    task automatic press_key(input int which, input int low_cycles);
        drive_key(which, 1'b0);
        repeat (low_cycles) tick();
        drive_key(which, 1'b1);
        repeat (4) tick();
    endtask

    task automatic feed_words(input int count, input bit keep);
        pixel_t w;
        logic   taken;
        for (int i = 0; i < count; i++)
        begin
            w              = random_word();
            img_word       = w;
            img_word_valid = 1'b1;
            do
            begin
                taken = img_word_ready;   // only moves with the fifo count
                tick();
            end
            while (!taken);
            if (keep)
                sent_words.push_back(w);
        end
        img_word_valid = 1'b0;
    endtask

    task automatic wait_packets(input int count);
        while (rx_len.size() < count)
            tick();
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_cnt++;
        if (expected !== actual)
        begin
            $display("FAILED %s: %s expected %0h actual %0h",
                     test_name, what, expected, actual);
            error_cnt++;
            test_errors++;
        end
    endtask

    task automatic compare_packet(input string what);
        pkt_len_t got_len;
        int       got_cnt;
        byte_t    got;
        if (rx_len.size() == 0)
        begin
            $display("%s: the %s packet never arrived", test_name, what);
            error_cnt++;
            test_errors++;
        end
        else
        begin
            got_len = rx_len.pop_front();
            got_cnt = rx_cnt.pop_front();
            check_value({what, " len"}, exp_bytes.size(), got_len);
            check_value({what, " bytes before last"}, exp_bytes.size(), got_cnt);
            for (int i = 0; i < got_cnt; i++)
            begin
                got = rx_data.pop_front();
                if (i < exp_bytes.size())
                    check_value($sformatf("%s byte %0d", what, i), exp_bytes[i], got);
            end
        end
        exp_bytes.delete();
    endtask

    // expected packet contents
    task automatic led_reference();
        exp_led_idx = (exp_led_idx + 1) % LED_PATTERNS;
        exp_bytes.push_back(8'hA5);
        exp_bytes.push_back(8'h01);
        exp_bytes.push_back(byte_t'(exp_led_idx));
        exp_bytes.push_back(~byte_t'(exp_led_idx));
    endtask

    task automatic mode_reference();
        logic [15:0] cmd;
        cmd        = exp_mode_b ? 16'h0003 : 16'h0001;
        exp_mode_b = !exp_mode_b;
        exp_bytes.push_back(cmd[15:8]);
        exp_bytes.push_back(cmd[7:0]);
    endtask

    task automatic image_reference();
        pixel_t w;
        exp_bytes.push_back(exp_seq[15:8]);
        exp_bytes.push_back(exp_seq[7:0]);
        exp_seq = exp_seq + 16'd1;
        for (int i = 0; i < 4; i++)
        begin
            w = sent_words.pop_front();
            for (int j = 3; j >= 0; j--)
                exp_bytes.push_back(w[8*j +: 8]);   // msb first
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        test_cnt++;
    endtask

    task automatic report_test();
        if (test_errors == 0)
            $display("test %-14s ok", test_name);
        else
            $display("test %-14s %0d error(s)", test_name, test_errors);
    endtask

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------
    task automatic led_command_test();
        start_test("led_command");
        for (int n = 1; n <= 3; n++)
        begin
            press_key(2, 24);
            wait_packets(1);
            led_reference();
            compare_packet($sformatf("led %0d", n));
        end
        report_test();
    endtask

    task automatic mode_command_test();
        start_test("mode_command");
        for (int n = 0; n < 3; n++)
        begin
            press_key(4, 24);
            wait_packets(1);
            mode_reference();
            compare_packet($sformatf("mode %0d", n));
        end
        report_test();
    endtask

    task automatic image_mode_test();
        start_test("image_mode");
        press_key(3, 24);
        check_value("img_mode on", 1, img_mode);
        exp_seq = '0;
        sent_words.delete();
        feed_words(12, 1'b1);
        wait_packets(3);
        for (int n = 0; n < 3; n++)
        begin
            image_reference();
            compare_packet($sformatf("image %0d", n));
        end
        press_key(3, 24);
        check_value("img_mode off", 0, img_mode);
        feed_words(4, 1'b0);              // mode off, words dropped
        repeat (40) tick();
        check_value("packets with mode off", 0, rx_len.size());
        press_key(3, 24);                 // re-enter, sequence restarts
        exp_seq = '0;
        sent_words.delete();
        feed_words(4, 1'b1);
        wait_packets(1);
        image_reference();
        compare_packet("image restart");
        report_test();
    endtask

    task automatic priority_test();
        start_test("priority");
        random_ready = 1'b1;
        feed_words(4, 1'b1);
        press_key(4, 24);                 // lands inside the image packet
        feed_words(4, 1'b1);
        wait_packets(3);
        random_ready = 1'b0;
        udp_tx_ready = 1'b1;
        image_reference();
        compare_packet("image before mode");
        mode_reference();
        compare_packet("mode");
        image_reference();
        compare_packet("image after mode");
        press_key(2, 24);                 // led must wait while image mode is on
        repeat (40) tick();
        check_value("led packets in image mode", 0, rx_len.size());
        press_key(3, 24);
        check_value("img_mode off", 0, img_mode);
        wait_packets(1);
        led_reference();
        compare_packet("held led");
        report_test();
    endtask

    task automatic backpressure_test();
        start_test("backpressure");
        press_key(3, 24);
        exp_seq = '0;
        sent_words.delete();
        udp_tx_ready = 1'b0;
        feed_words(16, 1'b1);
        check_value("img_word_ready when full", 0, img_word_ready);
        check_value("udp_tx_valid stalled", 1, udp_tx_valid);
        press_key(4, 24);
        repeat (20) tick();
        // stalled image packet still on its first byte
        check_value("udp_tx_valid after mode press", 1, udp_tx_valid);
        check_value("stalled packet len", 18, udp_tx.len);
        check_value("stalled first byte", 8'h00, udp_tx.data);
        udp_tx_ready = 1'b1;
        wait_packets(5);
        image_reference();
        compare_packet("image 0");
        mode_reference();
        compare_packet("mode");
        for (int n = 1; n < 4; n++)
        begin
            image_reference();
            compare_packet($sformatf("image %0d", n));
        end
        press_key(3, 24);
        check_value("img_mode off", 0, img_mode);
        report_test();
    endtask

    task automatic debounce_test();
        start_test("debounce");
        press_key(2, 8);                  // shorter than the debounce window
        repeat (40) tick();
        check_value("packets after glitch", 0, rx_len.size());
        press_key(2, 24);
        wait_packets(1);
        led_reference();
        compare_packet("led after glitch");
        report_test();
    endtask

    initial
    begin
        key1           = 1'b0;
        key2           = 1'b1;
        key3           = 1'b1;
        key4           = 1'b1;
        img_word       = '0;
        img_word_valid = 1'b0;
        udp_tx_ready   = 1'b1;
        repeat (16) tick();
        key1 = 1'b1;
        repeat (4) tick();

        led_command_test();
        mode_command_test();
        image_mode_test();
        priority_test();
        backpressure_test();
        debounce_test();

        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 test_cnt, check_cnt, error_cnt, dut.u_arbiter.u_checker.fail_count);
        if (error_cnt == 0 && dut.u_arbiter.u_checker.fail_count == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// File: testbench/udp_app_checker.sv
`timescale 1ns/1ps

module udp_app_checker (
    input logic                   clk_25_out,
    input logic                   key1,
    input udp_app_pkg::app_beat_t out_beat,
    input logic                   out_valid,
    input logic                   out_ready
);
    int fail_count = 0;  // assertion failures so far

    // nothing offered toward the stack while reset is held
    valid_in_reset: assert property (@(posedge clk_25_out) !key1 |-> !out_valid)
    else
    begin
        fail_count++;
        $error("udp_tx_valid high during reset");
    end

    // a stalled beat stays put
    stall_stable: assert property (@(posedge clk_25_out) disable iff (!key1)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
    else
    begin
        fail_count++;
        $error("udp_tx beat changed or dropped while stalled");
    end

    // len field same on every beat of one packet
    len_constant: assert property (@(posedge clk_25_out) disable iff (!key1)
        out_valid && out_ready && !out_beat.last |=> out_beat.len == $past(out_beat.len))
    else
    begin
        fail_count++;
        $error("udp_tx len changed inside a packet");
    end

endmodule
